// File: maxpool_consts.svh
// maxpool engine sizes.
// lane geometry, row length and word widths for the whole design.
// pooling is always 2x2 over MEMBERS beats per row.

`ifndef MAXPOOL_CONSTS_SVH
`define MAXPOOL_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lane geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define UNITS 4       // units per group.
`define GROUPS 2      // groups per beat.

// beats in one pixel row, power of two.
`define MEMBERS 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define WORD_WIDTH 8  // signed pixel word.
`define USER_WIDTH 2  // mode bits on s_user.

`endif

// File: source/maxpool_data_pkg.sv
// maxpool data types.
// pixel words, one-word-per-lane vectors and the flat two-copy beat
// that travels on s_data and m_data.

`default_nettype none

`include "maxpool_consts.svh"

package maxpool_data_pkg;

  // lanes per copy, lane index is g*UNITS+u.
  localparam int LANES = `GROUPS * `UNITS;
  localparam int BEAT_WIDTH = 2 * LANES * `WORD_WIDTH;  // both copies.

  // one signed pixel.
  typedef logic signed [`WORD_WIDTH-1:0] word_t;

  // one word per lane, lane 0 in the low bits.
  typedef word_t [LANES-1:0] lanes_t;

  // flat beat, copy 1 in the upper half, copy 0 below.
  typedef logic [BEAT_WIDTH-1:0] beat_t;

  // one keep bit per word, same ordering as beat_t.
  typedef logic [2*LANES-1:0] keep_t;

endpackage

`default_nettype wire

// File: source/maxpool_ctrl_pkg.sv
// maxpool control types.
// row state, row-beat counter and the mode bit positions in s_user.

`default_nettype none

`include "maxpool_consts.svh"

package maxpool_ctrl_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // mode bits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int IS_NOT_MAX = 0;  // pass-through requested.
  localparam int IS_MAX = 1;      // 2x2 pooling requested.

  // first row fills the buffer, second row pools against it.
  typedef enum logic {
    row_first  = 1'b0,
    row_second = 1'b1
  } row_state_e;

  // handshakes within the current row.
  typedef logic [$clog2(`MEMBERS)-1:0] count_t;

endpackage

`default_nettype wire

// File: source/maxpool_ctrl_if.sv
// maxpool control bus.
// strobes from the controller that steer the comparator muxes,
// the row buffer and the output stage.

`default_nettype none

interface maxpool_ctrl_if;

  logic sel_stored;    // compare buffer head against tail.
  logic buf_head_en;   // head register loads.
  logic buf_shift_en;  // rest of the chain shifts.
  logic delay_en;      // pass-through register loads.
  logic out_max;       // current output beat is pooled.

  // controller side.
  modport ctrl (
    output sel_stored,
    output buf_head_en,
    output buf_shift_en,
    output delay_en,
    output out_max
  );

  // datapath side.
  modport dp (
    input sel_stored,
    input buf_head_en,
    input buf_shift_en,
    input delay_en,
    input out_max
  );

endinterface

`default_nettype wire

// File: source/maxpool_ctrl.sv
// maxpool controller.
// counts handshakes per row, tracks which row is in flight and stalls
// the input for one cycle after every second-row beat so the comparator
// can be reused on stored values. builds the output valid and last.

`default_nettype none

`include "maxpool_consts.svh"

module maxpool_ctrl (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    clken,
  input  wire                    s_valid,
  input  wire  [`USER_WIDTH-1:0] s_user,
  output logic                   s_ready,
  output logic                   m_valid,
  output logic                   m_last,
  maxpool_ctrl_if.ctrl           ctrl
);

  localparam maxpool_ctrl_pkg::count_t LAST_BEAT =
    maxpool_ctrl_pkg::count_t'(`MEMBERS - 1);

  logic                          handshake;
  logic                          is_max;
  logic                          is_not_max;
  logic                          row_end;      // final beat of the row.
  maxpool_ctrl_pkg::count_t      count;
  maxpool_ctrl_pkg::row_state_e  state;
  logic                          stall;        // cycle after a second-row beat.
  logic                          pass_valid;   // pass-through beat out.
  logic                          max_p1;       // pooled beat, first stage.
  logic                          max_valid;    // pooled beat out.
  logic                          both_second;  // both modes in second row.

  assign is_max = s_user[maxpool_ctrl_pkg::IS_MAX];
  assign is_not_max = s_user[maxpool_ctrl_pkg::IS_NOT_MAX];
  assign handshake = clken && s_valid && s_ready;  // clken freezes everything.
  assign row_end = (count == LAST_BEAT);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // row counter and row state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
      state <= maxpool_ctrl_pkg::row_first;
    end else if (handshake) begin
      count <= row_end ? '0 : count + 1'b1;  // wraps per row.
      // rows only alternate when pooling.
      if (row_end && is_max) begin
        state <= (state == maxpool_ctrl_pkg::row_first) ?
                 maxpool_ctrl_pkg::row_second : maxpool_ctrl_pkg::row_first;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stall and valid pipeline
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stall       <= 1'b0;
      pass_valid  <= 1'b0;
      max_p1      <= 1'b0;
      max_valid   <= 1'b0;
      both_second <= 1'b0;
    end else if (clken) begin
      stall      <= handshake && (state == maxpool_ctrl_pkg::row_second);
      pass_valid <= handshake && is_not_max;  // one stage.
      max_p1     <= handshake && is_max && (state == maxpool_ctrl_pkg::row_second);
      max_valid  <= max_p1;                   // second stage.
      // held between beats, so it also covers the pooled beat.
      if (handshake) begin
        both_second <= is_max && is_not_max &&
                       (state == maxpool_ctrl_pkg::row_second);
      end
    end
  end

  assign s_ready = !stall;  // no new beat while comparing stored values.

  // datapath strobes.
  assign ctrl.sel_stored   = stall;
  assign ctrl.buf_head_en  = (handshake && is_max) || stall;  // reload pooled result.
  assign ctrl.buf_shift_en = handshake && is_max;
  assign ctrl.delay_en     = handshake && is_not_max;
  assign ctrl.out_max      = max_valid;

  // pass-through and pooled beats never land in the same cycle.
  assign m_valid = pass_valid || max_valid;

  // counter is back at zero right after the final beat of a row.
  assign m_last = m_valid && ((count == '0) || both_second);

endmodule

`default_nettype wire

// File: source/pair_comparator.sv
// pair comparator.
// per lane, picks either the two copies of the incoming beat or the
// two stored row-buffer words and returns the signed larger one.

`default_nettype none

module pair_comparator (
  input  wire maxpool_data_pkg::beat_t  s_data,
  input  wire maxpool_data_pkg::lanes_t stored_a,  // buffer head.
  input  wire maxpool_data_pkg::lanes_t stored_b,  // buffer tail.
  maxpool_ctrl_if.dp                    ctrl,
  output maxpool_data_pkg::lanes_t      max_out
);

  maxpool_data_pkg::lanes_t copy_0;  // left pixel of each pair.
  maxpool_data_pkg::lanes_t copy_1;  // right pixel.

  assign {copy_1, copy_0} = s_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one mux pair and one comparator per lane
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar l = 0; l < maxpool_data_pkg::LANES; l++) begin : g_lane
    maxpool_data_pkg::word_t in_a;
    maxpool_data_pkg::word_t in_b;

    // horizontal pair, or first row against second row during stall.
    assign in_a = ctrl.sel_stored ? stored_a[l] : copy_0[l];
    assign in_b = ctrl.sel_stored ? stored_b[l] : copy_1[l];

    // signed compare, ties take in_b which is the same value.
    assign max_out[l] = (in_a > in_b) ? in_a : in_b;
  end

endmodule

`default_nettype wire

// File: source/row_buffer.sv
// row buffer.
// chain of MEMBERS+1 lane registers. the head takes every comparator
// result, the rest shift on handshakes only, so the first-row maximum
// of beat k sits in the tail while second-row beat k is compared.

`default_nettype none

`include "maxpool_consts.svh"

module row_buffer (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           clken,
  maxpool_ctrl_if.dp                    ctrl,
  input  wire maxpool_data_pkg::lanes_t max_in,
  output maxpool_data_pkg::lanes_t      head,
  output maxpool_data_pkg::lanes_t      tail
);

  localparam int DEPTH = `MEMBERS + 1;  // head plus one row.

  maxpool_data_pkg::lanes_t chain [DEPTH];  // index 0 is the head.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // head and shift chain
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int m = 0; m < DEPTH; m++) begin
        chain[m] <= '0;
      end
    end else if (clken) begin
      // also loads in the stall cycle, holding the pooled result.
      if (ctrl.buf_head_en) begin
        chain[0] <= max_in;
      end
      // pooled results get pushed in too, but never reach the tail
      // before the next first row overwrites them.
      if (ctrl.buf_shift_en) begin
        for (int m = 1; m < DEPTH; m++) begin
          chain[m] <= chain[m-1];
        end
      end
    end
  end

  assign head = chain[0];        // newest horizontal max.
  assign tail = chain[DEPTH-1];  // same beat, one row back.

endmodule

`default_nettype wire

// File: source/output_stage.sv
// output stage.
// holds the last pass-through beat and selects between it and the
// pooled lanes. pooled beats carry data on copy 0 only, copy 1 is
// masked off through m_keep.

`default_nettype none

module output_stage (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           clken,
  maxpool_ctrl_if.dp                    ctrl,
  input  wire maxpool_data_pkg::beat_t  s_data,
  input  wire maxpool_data_pkg::lanes_t pooled,  // buffer head.
  output maxpool_data_pkg::beat_t       m_data,
  output maxpool_data_pkg::keep_t       m_keep
);

  localparam int LANES = maxpool_data_pkg::LANES;

  maxpool_data_pkg::beat_t  delayed;  // pass-through beat, one cycle late.
  maxpool_data_pkg::lanes_t held_0;
  maxpool_data_pkg::lanes_t held_1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pass-through delay
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      delayed <= '0;
    end else if (clken && ctrl.delay_en) begin
      delayed <= s_data;  // only non-max beats are captured.
    end
  end

  assign {held_1, held_0} = delayed;

  // output select and keep.
  always_comb begin
    if (ctrl.out_max) begin
      m_data = {held_1, pooled};                  // copy 1 is don't care.
      m_keep = {{LANES{1'b0}}, {LANES{1'b1}}};    // copy 0 words only.
    end else begin
      m_data = {held_1, held_0};
      m_keep = '1;
    end
  end

endmodule

`default_nettype wire

// File: source/maxpool_engine.sv
// maxpool engine, top level.
// 2x2 max pooling on a stream of two-copy beats. non-max beats pass
// through one cycle late, pooled beats leave on copy 0 two cycles after
// the second-row beat. no output back-pressure, downstream always takes
// a beat when m_valid is high.

`default_nettype none

`include "maxpool_consts.svh"

module maxpool_engine (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          clken,
  input  wire                          s_valid,
  input  wire maxpool_data_pkg::beat_t s_data,
  input  wire [`USER_WIDTH-1:0]        s_user,
  output logic                         s_ready,
  output logic                         m_valid,
  output maxpool_data_pkg::beat_t      m_data,
  output maxpool_data_pkg::keep_t      m_keep,
  output logic                         m_last
);

  maxpool_ctrl_if ctrl_bus ();  // controller to datapath strobes.

  maxpool_data_pkg::lanes_t max_out;  // comparator result.
  maxpool_data_pkg::lanes_t head;     // buffer head, pooled result.
  maxpool_data_pkg::lanes_t tail;     // first-row max of the same beat.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  maxpool_ctrl ctrl_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .clken   (clken),
    .s_valid (s_valid),
    .s_user  (s_user),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_last  (m_last),
    .ctrl    (ctrl_bus)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  pair_comparator comparator_i (
    .s_data   (s_data),
    .stored_a (head),
    .stored_b (tail),
    .ctrl     (ctrl_bus),
    .max_out  (max_out)
  );

  row_buffer buffer_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .clken  (clken),
    .ctrl   (ctrl_bus),
    .max_in (max_out),
    .head   (head),
    .tail   (tail)
  );

  output_stage out_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .clken  (clken),
    .ctrl   (ctrl_bus),
    .s_data (s_data),
    .pooled (head),  // pooled value lands in the head after the stall.
    .m_data (m_data),
    .m_keep (m_keep)
  );

endmodule

`default_nettype wire

// File: verification/maxpool_engine_tb.sv
// maxpool engine testbench.
// walks a table of modes and row counts, feeds LFSR pixel data, predicts
// every output beat from the pooling rules and checks the DUT against it.
// also tracks the one-cycle input stall after each second-row beat.

`default_nettype none

`include "maxpool_consts.svh"

module maxpool_engine_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int LANES = `GROUPS * `UNITS;
  localparam int W = `WORD_WIDTH;
  localparam int ENTRIES = 8;
  localparam int WAIT_LIMIT = 16;  // cycles per wait.

  typedef struct packed {
    logic [`USER_WIDTH-1:0] mode;          // s_user bits.
    logic [3:0]             rows;          // even for pooling modes.
    logic [1:0]             kind;          // 0 random, 1 negative, 2 narrow.
    logic                   reset_before;
  } entry_t;

  typedef struct packed {
    maxpool_data_pkg::beat_t data;
    maxpool_data_pkg::keep_t keep;
    logic                    last;
  } out_t;

  logic                    clk;
  logic                    rst_n;
  logic                    clken;
  logic                    s_valid;
  maxpool_data_pkg::beat_t s_data;
  logic [`USER_WIDTH-1:0]  s_user;
  logic                    s_ready;
  logic                    m_valid;
  maxpool_data_pkg::beat_t m_data;
  maxpool_data_pkg::keep_t m_keep;
  logic                    m_last;

  entry_t                   stim_table [ENTRIES];
  out_t                     expected [$];         // predicted output beats.
  maxpool_data_pkg::lanes_t first_max [`MEMBERS];  // model of the row buffer.
  logic [31:0]              lfsr;
  logic                     beat_second;  // beat on the bus pools.
  logic                     stall_due;    // s_ready must be low now.
  int                       n_out;

  maxpool_engine maxpool_engine_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .clken   (clken),
    .s_valid (s_valid),
    .s_data  (s_data),
    .s_user  (s_user),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_keep  (m_keep),
    .m_last  (m_last)
  );

  always #2 clk = ~clk;  // 4 ns period.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // galois LFSR stepped once per bit.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    end
    return bits;
  endfunction

  function automatic maxpool_data_pkg::word_t make_word(input logic [1:0] kind);
    logic [31:0] r;
    if (kind == 2'd1) begin
      r = take_bits(W - 1);
      return {1'b1, r[W-2:0]};  // always negative.
    end else if (kind == 2'd2) begin
      r = take_bits(2);
      return {{(W-2){r[1]}}, r[1:0]};  // -2 to 1 with lots of ties.
    end
    r = take_bits(W);
    return r[W-1:0];
  endfunction

  function automatic maxpool_data_pkg::word_t pair_max(
    input maxpool_data_pkg::word_t a,
    input maxpool_data_pkg::word_t b
  );
    return (a >= b) ? a : b;  // signed.
  endfunction

  // word-wide mask from keep bits.
  function automatic maxpool_data_pkg::beat_t keep_mask(input maxpool_data_pkg::keep_t keep);
    maxpool_data_pkg::beat_t m;
    for (int i = 0; i < 2 * LANES; i++) begin
      m[i*W +: W] = {W{keep[i]}};
    end
    return m;
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display(">>> FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic fill_table();
    stim_table[0] = '{mode: 2'b01, rows: 4'd2, kind: 2'd0, reset_before: 1'b0};
    stim_table[1] = '{mode: 2'b10, rows: 4'd2, kind: 2'd0, reset_before: 1'b0};
    stim_table[2] = '{mode: 2'b11, rows: 4'd2, kind: 2'd0, reset_before: 1'b0};
    stim_table[3] = '{mode: 2'b10, rows: 4'd4, kind: 2'd1, reset_before: 1'b0};
    stim_table[4] = '{mode: 2'b11, rows: 4'd2, kind: 2'd2, reset_before: 1'b1};
    stim_table[5] = '{mode: 2'b01, rows: 4'd1, kind: 2'd1, reset_before: 1'b0};
    stim_table[6] = '{mode: 2'b10, rows: 4'd2, kind: 2'd2, reset_before: 1'b0};
    stim_table[7] = '{mode: 2'b11, rows: 4'd4, kind: 2'd0, reset_before: 1'b0};
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model and driver
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic send_beat(input entry_t e, input int row, input int k);
    maxpool_data_pkg::lanes_t copy_0;
    maxpool_data_pkg::lanes_t copy_1;
    maxpool_data_pkg::lanes_t hmax;
    maxpool_data_pkg::lanes_t pooled;
    logic                     is_max;
    logic                     is_not_max;
    logic                     second;
    logic [31:0]              gap;
    out_t                     beat;
    int                       waited;
    is_max = e.mode[maxpool_ctrl_pkg::IS_MAX];
    is_not_max = e.mode[maxpool_ctrl_pkg::IS_NOT_MAX];
    second = is_max && row[0];  // odd rows are second rows.
    for (int l = 0; l < LANES; l++) begin
      copy_0[l] = make_word(e.kind);
      copy_1[l] = make_word(e.kind);
      hmax[l] = pair_max(copy_0[l], copy_1[l]);  // horizontal pair.
    end
    if (is_not_max) begin
      beat.data = {copy_1, copy_0};
      beat.keep = '1;
      beat.last = (k == `MEMBERS - 1) || second;
      expected.push_back(beat);
    end
    if (second) begin
      for (int l = 0; l < LANES; l++) begin
        pooled[l] = pair_max(hmax[l], first_max[k][l]);  // vertical pair.
      end
      beat.data = {{LANES{{W{1'b0}}}}, pooled};  // copy 1 unchecked.
      beat.keep = {{LANES{1'b0}}, {LANES{1'b1}}};
      beat.last = (k == `MEMBERS - 1) || is_not_max;
      expected.push_back(beat);
    end else if (is_max) begin
      first_max[k] = hmax;
    end
    s_valid <= 1'b1;
    s_data <= {copy_1, copy_0};
    s_user <= e.mode;
    beat_second = second;
    // held until accepted across any stall.
    waited = 0;
    @(negedge clk);
    while (!s_ready) begin
      assert (waited < WAIT_LIMIT) else stop_run("input beat was never accepted");
      waited++;
      @(negedge clk);
    end
    @(posedge clk);  // transfer edge.
    gap = take_bits(1);
    if (gap[0]) begin
      s_valid <= 1'b0;
      beat_second = 1'b0;
      @(posedge clk);
    end
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    while (expected.size() > 0) begin
      assert (waited < WAIT_LIMIT) else stop_run("predicted output beats never appeared");
      waited++;
      @(negedge clk);
    end
  endtask

  // a few quiet cycles that must carry no stray beat.
  task automatic check_idle();
    repeat (3) @(negedge clk);
    assert (s_ready) else stop_run("s_ready is low while the input is idle");
    assert (!m_valid) else stop_run("m_valid is high while the input is idle");
    @(posedge clk);  // next drive starts on a rising edge.
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    s_valid <= 1'b0;
    beat_second = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    check_idle();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // monitor on the falling edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk) begin : monitor
    out_t                    exp_beat;
    maxpool_data_pkg::beat_t mask;
    if (!rst_n) begin
      stall_due = 1'b0;
    end else begin
      assert (s_ready == !stall_due) else
        stop_run($sformatf("mismatch at %0t ns: s_ready is %0b", $time, s_ready));
      stall_due = clken && s_valid && s_ready && beat_second;  // next cycle.
      if (m_valid) begin
        assert (expected.size() > 0) else stop_run("output beat appeared with none predicted");
        if (expected.size() > 0) begin
          exp_beat = expected.pop_front();
          mask = keep_mask(exp_beat.keep);
          assert (m_keep == exp_beat.keep) else
            stop_run($sformatf("mismatch at %0t ns: m_keep %h, expected %h",
                               $time, m_keep, exp_beat.keep));
          assert ((m_data & mask) == (exp_beat.data & mask)) else
            stop_run($sformatf("mismatch at %0t ns: m_data %h, expected %h",
                               $time, m_data & mask, exp_beat.data & mask));
          assert (m_last == exp_beat.last) else
            stop_run($sformatf("mismatch at %0t ns: m_last %0b, expected %0b",
                               $time, m_last, exp_beat.last));
          n_out++;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    clken = 1'b1;  // state never frozen here.
    s_valid = 1'b0;
    s_data = '0;
    s_user = '0;
    beat_second = 1'b0;
    stall_due = 1'b0;
    lfsr = 32'd98584;
    n_out = 0;
    fill_table();
    apply_reset();
    for (int i = 0; i < ENTRIES; i++) begin
      if (stim_table[i].reset_before) begin
        apply_reset();
      end
      for (int r = 0; r < int'(stim_table[i].rows); r++) begin
        for (int k = 0; k < `MEMBERS; k++) begin
          send_beat(stim_table[i], r, k);
        end
      end
      s_valid <= 1'b0;
      beat_second = 1'b0;
      drain_outputs();
      check_idle();  // back in the first row with nothing pending.
    end
    $display("%0d output beats checked", n_out);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
source/maxpool_data_pkg.sv
source/maxpool_ctrl_pkg.sv
source/maxpool_ctrl_if.sv
source/maxpool_ctrl.sv
source/pair_comparator.sv
source/row_buffer.sv
source/output_stage.sv
source/maxpool_engine.sv
verification/maxpool_engine_tb.sv

// File: Makefile
# Verilator build and run for the maxpool engine testbench.
# Every variable can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= maxpool_engine_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0 -Wno-fatal
PASS_TEXT ?= >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail unless the pass line is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
